//--- id_stage.f
+incdir+test
source/id_pkg.sv
source/id_dec_if.sv
source/id_decoder.sv
source/id_gpr.sv
source/id_branch.sv
source/id_stage.sv
test/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f id_stage.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/id_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- source/id_branch.sv
// branch and jump resolution in decode; assumes a 4-byte aligned pc, jalr target has bit 0 cleared
`timescale 1ns/1ps
`default_nettype none

module id_branch import id_pkg::*; (
  id_dec_if.consumer dec,
  input  xlen_t      i_rs1data,
  input  xlen_t      i_rs2data,
  input  xlen_t      i_pc,
  output logic       o_br_taken,
  output xlen_t      o_br_target
);

  logic  cond;
  logic  eq;
  logic  lt_s;
  logic  lt_u;
  xlen_t pc_sum;
  xlen_t jalr_sum;

  assign eq   = (i_rs1data == i_rs2data);
  assign lt_s = ($signed(i_rs1data) < $signed(i_rs2data));
  assign lt_u = (i_rs1data < i_rs2data);

  always_comb begin
    case (dec.brfunc)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt_s;
      F3_BGE:  cond = !lt_s;
      F3_BLTU: cond = lt_u;
      F3_BGEU: cond = !lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign pc_sum   = i_pc + dec.imm;
  assign jalr_sum = i_rs1data + dec.imm;

  // jumps always redirect
  assign o_br_taken  = dec.jal || dec.jalr || (dec.bren && cond);
  assign o_br_target = dec.jalr ? {jalr_sum[63:1], 1'b0} : pc_sum;

  always_comb begin
    if (o_br_taken) begin
      a_target_even : assert (!o_br_target[0])
        else $error("odd redirect target %h", o_br_target);
    end
  end

endmodule

`default_nettype wire

//--- source/id_dec_if.sv
// decoded instruction fields; the decoder is the only driver, rd reads zero when nothing is written back
`timescale 1ns/1ps
`default_nettype none

interface id_dec_if import id_pkg::*; ();

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  logic      bren;
  logic      jal;
  logic      jalr;
  br_func_t  brfunc;
  logic      gpr_wen;
  logic      mem_ren;
  logic      mem_wen;
  mem_op_t   mem_op;
  alu_op_t   alu_op;
  logic      alu_src2_sel;
  logic      invalid;

  modport producer (
    output rs1, rs2, rd, imm, bren, jal, jalr, brfunc,
    output gpr_wen, mem_ren, mem_wen, mem_op, alu_op, alu_src2_sel, invalid
  );

  modport consumer (
    input rs1, rs2, rd, imm, bren, jal, jalr, brfunc,
    input gpr_wen, mem_ren, mem_wen, mem_op, alu_op, alu_src2_sel, invalid
  );

endinterface

`default_nettype wire

//--- source/id_decoder.sv
// purely combinational rv64 subset decoder; any other encoding is flagged invalid with all side effects cleared
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
  input  inst_t      i_inst,
  id_dec_if.producer dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       valid_enc;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // sign-extended immediates, one per format
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    dec.rs1          = i_inst[19:15];
    dec.rs2          = i_inst[24:20];
    dec.brfunc       = funct3;
    dec.mem_op       = funct3;
    dec.imm          = '0;
    dec.bren         = 1'b0;
    dec.jal          = 1'b0;
    dec.jalr         = 1'b0;
    dec.gpr_wen      = 1'b0;
    dec.mem_ren      = 1'b0;
    dec.mem_wen      = 1'b0;
    dec.alu_op       = ALU_ADD;
    dec.alu_src2_sel = ALU_SRC2_IMM;  // only op and branch use rs2
    valid_enc        = 1'b0;

    case (opcode)
      OPC_LUI: begin
        valid_enc   = 1'b1;
        dec.gpr_wen = 1'b1;
        dec.imm     = imm_u;
        dec.alu_op  = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        valid_enc   = 1'b1;
        dec.gpr_wen = 1'b1;
        dec.imm     = imm_u;
      end
      OPC_JAL: begin
        valid_enc   = 1'b1;
        dec.gpr_wen = 1'b1;
        dec.jal     = 1'b1;
        dec.imm     = imm_j;
      end
      OPC_JALR: begin
        valid_enc   = (funct3 == F3_JALR);
        dec.gpr_wen = 1'b1;
        dec.jalr    = 1'b1;
        dec.imm     = imm_i;
      end
      OPC_BRANCH: begin
        valid_enc        = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        dec.bren         = 1'b1;
        dec.imm          = imm_b;
        dec.alu_src2_sel = ALU_SRC2_REG;
      end
      OPC_LOAD: begin
        valid_enc   = funct3 inside {F3_WORD, F3_DWORD};
        dec.gpr_wen = 1'b1;
        dec.mem_ren = 1'b1;
        dec.imm     = imm_i;
      end
      OPC_STORE: begin
        valid_enc   = funct3 inside {F3_WORD, F3_DWORD};
        dec.mem_wen = 1'b1;
        dec.imm     = imm_s;
      end
      OPC_OPIMM: begin
        valid_enc   = (funct3 == F3_ADD);  // addi only
        dec.gpr_wen = 1'b1;
        dec.imm     = imm_i;
      end
      OPC_OP: begin
        valid_enc        = (funct3 == F3_ADD) && (funct7 == F7_BASE || funct7 == F7_SUB);
        dec.gpr_wen      = 1'b1;
        dec.alu_src2_sel = ALU_SRC2_REG;
        dec.alu_op       = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
      end
      default: ;
    endcase

    // unsupported encodings pass on as harmless bubbles
    if (!valid_enc) begin
      dec.bren    = 1'b0;
      dec.jal     = 1'b0;
      dec.jalr    = 1'b0;
      dec.gpr_wen = 1'b0;
      dec.mem_ren = 1'b0;
      dec.mem_wen = 1'b0;
    end
    dec.invalid = !valid_enc;
    dec.rd      = dec.gpr_wen ? i_inst[11:7] : '0;  // no false hazards downstream
  end

  always_comb begin
    a_mem_excl : assert (!(dec.mem_ren && dec.mem_wen))
      else $error("decoder drives load and store together");
  end

endmodule

`default_nettype wire

//--- source/id_gpr.sv
// 32 x 64 register file, two async read ports and one write port; x0 is hardwired to zero, no write-to-read bypass
`timescale 1ns/1ps
`default_nettype none

module id_gpr import id_pkg::*; (
  input  logic      i_clk,
  // read port 1
  input  reg_addr_t i_raddr1,
  output xlen_t     o_rdata1,
  // read port 2
  input  reg_addr_t i_raddr2,
  output xlen_t     o_rdata2,
  // write port
  input  logic      i_wen,
  input  reg_addr_t i_waddr,
  input  xlen_t     i_wdata
);

  xlen_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_x0_zero : assert property (
    @(posedge i_clk)
    ((i_raddr1 == '0) |-> (o_rdata1 == '0)) and ((i_raddr2 == '0) |-> (o_rdata2 == '0))
  ) else $error("x0 read returned nonzero data");

endmodule

`default_nettype wire

//--- source/id_pkg.sv
// shared widths and encodings for the rv64 decode stage; only the lui/auipc/jal/jalr/branch/ld/lw/sd/sw/addi/add/sub subset is encoded
`default_nettype none

package id_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [2:0]  mem_op_t;   // same coding as load/store funct3
  typedef logic [2:0]  br_func_t;  // same coding as branch funct3

  // alu operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_PASS_B = 4'd2;  // lui

  // operand 2 select
  localparam logic ALU_SRC2_REG = 1'b0;
  localparam logic ALU_SRC2_IMM = 1'b1;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // branch conditions
  localparam br_func_t F3_BEQ  = 3'b000;
  localparam br_func_t F3_BNE  = 3'b001;
  localparam br_func_t F3_BLT  = 3'b100;
  localparam br_func_t F3_BGE  = 3'b101;
  localparam br_func_t F3_BLTU = 3'b110;
  localparam br_func_t F3_BGEU = 3'b111;

  // memory sizes, lw/sw and ld/sd
  localparam mem_op_t F3_WORD  = 3'b010;
  localparam mem_op_t F3_DWORD = 3'b011;

  localparam logic [2:0] F3_ADD  = 3'b000;  // addi, add, sub
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- source/id_stage.sv
// rv64 decode stage, one cycle latency; stalls on any es/ms/ws rd match with rs1/rs2 since there is no bypass
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  // allowin
  input  logic      i_es_allowin,
  output logic      o_ds_allowin,
  // from fs
  input  logic      i_fs_to_ds_valid,
  input  inst_t     i_fs_inst,
  input  xlen_t     i_fs_pc,
  // to es
  output logic      o_ds_to_es_valid,
  output xlen_t     o_rs1data,
  output xlen_t     o_rs2data,
  output xlen_t     o_imm,
  output xlen_t     o_pc,
  output reg_addr_t o_rd,
  output alu_op_t   o_alu_op,
  output logic      o_alu_src2_sel,
  output logic      o_gpr_wen,
  output logic      o_mem_ren,
  output logic      o_mem_wen,
  output mem_op_t   o_mem_op,
  output logic      o_invalid,
  // redirect to fs
  output logic      o_br_sel,
  output xlen_t     o_br_target,
  // write back
  input  logic      i_ws_wen,
  input  reg_addr_t i_ws_waddr,
  input  xlen_t     i_ws_wdata,
  // destinations in flight
  input  reg_addr_t i_es_rd,
  input  reg_addr_t i_ms_rd,
  input  reg_addr_t i_ws_rd
);

  logic  ds_valid;
  logic  ds_ready_go;
  inst_t ds_inst;
  xlen_t ds_pc;
  logic  es_hit;
  logic  ms_hit;
  logic  ws_hit;
  logic  hazard;
  logic  raw_hit;
  logic  br_taken;

  id_dec_if dec_if ();

  // rs fields compared even when unused by the instruction
  assign es_hit = (i_es_rd != '0) && (i_es_rd == dec_if.rs1 || i_es_rd == dec_if.rs2);
  assign ms_hit = (i_ms_rd != '0) && (i_ms_rd == dec_if.rs1 || i_ms_rd == dec_if.rs2);
  assign ws_hit = (i_ws_rd != '0) && (i_ws_rd == dec_if.rs1 || i_ws_rd == dec_if.rs2);
  assign hazard = es_hit || ms_hit || ws_hit;

  assign ds_ready_go      = !hazard;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_inst <= NOP_INST;
    end else if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_pc <= i_fs_pc;
    end
  end

  id_decoder u_dec (
    .i_inst (ds_inst),
    .dec    (dec_if.producer)
  );

  id_gpr u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (dec_if.rs1),
    .o_rdata1 (o_rs1data),
    .i_raddr2 (dec_if.rs2),
    .o_rdata2 (o_rs2data),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata)
  );

  id_branch u_br (
    .dec         (dec_if.consumer),
    .i_rs1data   (o_rs1data),
    .i_rs2data   (o_rs2data),
    .i_pc        (ds_pc),
    .o_br_taken  (br_taken),
    .o_br_target (o_br_target)
  );

  assign o_br_sel = o_ds_to_es_valid && br_taken;  // one redirect, on handoff only

  assign o_pc           = ds_pc;
  assign o_imm          = dec_if.imm;
  assign o_rd           = dec_if.rd;
  assign o_alu_op       = dec_if.alu_op;
  assign o_alu_src2_sel = dec_if.alu_src2_sel;
  assign o_gpr_wen      = dec_if.gpr_wen;
  assign o_mem_ren      = dec_if.mem_ren;
  assign o_mem_wen      = dec_if.mem_wen;
  assign o_mem_op       = dec_if.mem_op;
  assign o_invalid      = dec_if.invalid;

  // source fields straight from the instruction word, not from the decoder
  assign raw_hit = (i_es_rd != '0 && (i_es_rd == ds_inst[19:15] || i_es_rd == ds_inst[24:20]))
                || (i_ms_rd != '0 && (i_ms_rd == ds_inst[19:15] || i_ms_rd == ds_inst[24:20]))
                || (i_ws_rd != '0 && (i_ws_rd == ds_inst[19:15] || i_ws_rd == ds_inst[24:20]));

  a_no_hazard_issue : assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid |-> !raw_hit
  ) else $error("decode issued with a pending rs write");

endmodule

`default_nettype wire

//--- test/id_model.svh
// reference decode and branch model with a shadow register file; imm, alu_op and src2 select only defined for legal encodings
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

typedef struct packed {
  logic       legal;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  xlen_t      imm;
  logic [2:0] funct3;
  logic       bren;
  logic       jal;
  logic       jalr;
  logic       gpr_wen;
  logic       mem_ren;
  logic       mem_wen;
  alu_op_t    alu_op;
  logic       src2_reg;
} dec_model_t;

xlen_t shadow_gpr [32];

function automatic xlen_t shadow_read(input reg_addr_t a);
  shadow_read = (a == 5'd0) ? 64'd0 : shadow_gpr[a];
endfunction

task automatic shadow_write(input reg_addr_t a, input xlen_t v);
  if (a != 5'd0) begin
    shadow_gpr[a] = v;
  end
endtask

// nonzero destination matching either source field
function automatic logic hazard_hit(input reg_addr_t rd, input dec_model_t d);
  hazard_hit = (rd != 5'd0) && (rd == d.rs1 || rd == d.rs2);
endfunction

function automatic dec_model_t model_decode(input inst_t inst);
  dec_model_t d;
  logic [2:0] f3;
  logic       ls_size;
  f3       = inst[14:12];
  ls_size  = (f3 == F3_WORD) || (f3 == F3_DWORD);
  d        = '0;
  d.rs1    = inst[19:15];
  d.rs2    = inst[24:20];
  d.funct3 = f3;
  d.alu_op = ALU_ADD;
  case (inst[6:0])
    OPC_LUI, OPC_AUIPC: begin
      d.legal   = 1'b1;
      d.gpr_wen = 1'b1;
      d.imm     = {{33{inst[31]}}, inst[30:12], 12'h000};
      if (inst[6:0] == OPC_LUI) begin
        d.alu_op = ALU_PASS_B;
      end
    end
    OPC_JAL: begin
      d.legal   = 1'b1;
      d.gpr_wen = 1'b1;
      d.jal     = 1'b1;
      d.imm     = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    OPC_JALR: begin
      d.legal   = (f3 == 3'b000);
      d.gpr_wen = 1'b1;
      d.jalr    = 1'b1;
      d.imm     = {{53{inst[31]}}, inst[30:20]};
    end
    OPC_BRANCH: begin
      d.legal    = (f3[2:1] != 2'b01);  // 010 and 011 unused
      d.bren     = 1'b1;
      d.src2_reg = 1'b1;
      d.imm      = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    OPC_LOAD: begin
      d.legal   = ls_size;
      d.gpr_wen = 1'b1;
      d.mem_ren = 1'b1;
      d.imm     = {{53{inst[31]}}, inst[30:20]};
    end
    OPC_STORE: begin
      d.legal   = ls_size;
      d.mem_wen = 1'b1;
      d.imm     = {{53{inst[31]}}, inst[30:25], inst[11:7]};
    end
    OPC_OPIMM: begin
      d.legal   = (f3 == 3'b000);
      d.gpr_wen = 1'b1;
      d.imm     = {{53{inst[31]}}, inst[30:20]};
    end
    OPC_OP: begin
      d.legal    = (f3 == 3'b000) && ((inst[31:25] & 7'b1011111) == 7'd0);
      d.gpr_wen  = 1'b1;
      d.src2_reg = 1'b1;
      d.alu_op   = inst[30] ? ALU_SUB : ALU_ADD;
    end
    default: ;
  endcase
  if (!d.legal) begin
    d.bren    = 1'b0;
    d.jal     = 1'b0;
    d.jalr    = 1'b0;
    d.gpr_wen = 1'b0;
    d.mem_ren = 1'b0;
    d.mem_wen = 1'b0;
  end
  d.rd = d.gpr_wen ? inst[11:7] : 5'd0;
  model_decode = d;
endfunction

function automatic logic model_branch(input dec_model_t d, input xlen_t pc, input xlen_t a,
                                      input xlen_t b, output xlen_t target);
  logic taken;
  taken  = 1'b0;
  target = pc + d.imm;
  if (d.jal) begin
    taken = 1'b1;
  end else if (d.jalr) begin
    taken  = 1'b1;
    target = (a + d.imm) & ~64'd1;
  end else if (d.bren) begin
    case (d.funct3)
      3'b000:  taken = (a == b);
      3'b001:  taken = (a != b);
      3'b100:  taken = ($signed(a) < $signed(b));
      3'b101:  taken = ($signed(a) >= $signed(b));
      3'b110:  taken = (a < b);
      default: taken = (a >= b);
    endcase
  end
  model_branch = taken;
endfunction

`endif

//--- test/id_stage_tb.sv
// random fetch, write-back and hazard stimulus checked against the model; pcs are 4-byte aligned
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

  localparam int N_INST         = 300;
  localparam int FETCH_PCT      = 75;
  localparam int TIMEOUT_CYCLES = 12000;  // 4 x 300 x 8 plus margin

  logic      i_clk;
  logic      i_rst;
  logic      i_es_allowin;
  logic      o_ds_allowin;
  logic      i_fs_to_ds_valid;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc;
  logic      o_ds_to_es_valid;
  xlen_t     o_rs1data;
  xlen_t     o_rs2data;
  xlen_t     o_imm;
  xlen_t     o_pc;
  reg_addr_t o_rd;
  alu_op_t   o_alu_op;
  logic      o_alu_src2_sel;
  logic      o_gpr_wen;
  logic      o_mem_ren;
  logic      o_mem_wen;
  mem_op_t   o_mem_op;
  logic      o_invalid;
  logic      o_br_sel;
  xlen_t     o_br_target;
  logic      i_ws_wen;
  reg_addr_t i_ws_waddr;
  xlen_t     i_ws_wdata;
  reg_addr_t i_es_rd;
  reg_addr_t i_ms_rd;
  reg_addr_t i_ws_rd;

  integer      seed;
  int          cycle_count;
  int          consumed;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  string       cur_test;
  int unsigned branch_pct;
  int unsigned hazard_pct;
  int unsigned stall_pct;
  int unsigned write_pct;
  inst_t       pend_inst [$];  // accepted, not yet taken by es
  xlen_t       pend_pc [$];

  `include "id_model.svh"

  id_stage uut (.*);

  always #5 i_clk = ~i_clk;

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

  task automatic check(input string field, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      test_errors = test_errors + 1;
      $display("Error: test %s, %s expected %h, actual %h", cur_test, field, expected, actual);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  function automatic xlen_t rand_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    // small values make equal and ordered compares likely
    if (rand_below(4) == 0) begin
      rand_data = {{61{lo[2]}}, lo[2:0]};
    end else begin
      rand_data = {hi, lo};
    end
  endfunction

  function automatic inst_t gen_inst();
    logic [31:0] r;
    int unsigned kind;
    r    = $random(seed);
    kind = (rand_below(100) < branch_pct) ? 2 + rand_below(3) : rand_below(10);
    gen_inst = r;
    case (kind)
      0: gen_inst[6:0] = OPC_LUI;
      1: gen_inst[6:0] = OPC_AUIPC;
      2: gen_inst[6:0] = OPC_JAL;
      3: begin
        gen_inst[6:0]   = OPC_JALR;
        gen_inst[14:12] = 3'b000;
      end
      4: begin
        gen_inst[6:0] = OPC_BRANCH;
        gen_inst[14]  = gen_inst[14] | gen_inst[13];  // skip 010/011
      end
      5, 6: begin
        gen_inst[6:0]   = (kind == 5) ? OPC_LOAD : OPC_STORE;
        gen_inst[14:12] = {2'b01, r[12]};
      end
      7: begin
        gen_inst[6:0]   = OPC_OPIMM;
        gen_inst[14:12] = 3'b000;
      end
      8: begin
        gen_inst[6:0]   = OPC_OP;
        gen_inst[14:12] = 3'b000;
        gen_inst[31:25] = r[29] ? F7_SUB : F7_BASE;
      end
      default: ;  // raw word, mostly invalid
    endcase
  endfunction

  function automatic reg_addr_t pick_rd();
    logic [31:0] r;
    inst_t       held;
    r = $random(seed);
    if (pend_inst.size() != 0 && rand_below(100) < hazard_pct) begin
      held    = pend_inst[0];
      pick_rd = r[0] ? held[19:15] : held[24:20];  // may be x0
    end else if (r[1]) begin
      pick_rd = r[8:4];
    end else begin
      pick_rd = 5'd0;
    end
  endfunction

  task automatic drive_inputs();
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    r_hi = $random(seed);
    r_lo = $random(seed);
    i_fs_to_ds_valid = (rand_below(100) < FETCH_PCT);
    i_fs_inst        = gen_inst();
    i_fs_pc          = {r_hi, r_lo[31:2], 2'b00};
    i_es_allowin     = (rand_below(100) >= stall_pct);
    i_ws_wen         = (rand_below(100) < write_pct);
    i_ws_waddr       = (rand_below(100) < 10) ? 5'd0 : r_hi[4:0];
    i_ws_wdata       = rand_data();
    i_es_rd          = pick_rd();
    i_ms_rd          = pick_rd();
    i_ws_rd          = pick_rd();
  endtask

  // sample between edges, then advance the model past the next edge
  task automatic check_cycle();
    dec_model_t d;
    logic       held;
    logic       hz;
    logic       exp_valid;
    logic       exp_allowin;
    logic       taken;
    xlen_t      target;
    held = (pend_inst.size() != 0);
    d    = model_decode(NOP_INST);
    if (held) begin
      d = model_decode(pend_inst[0]);
    end
    hz          = hazard_hit(i_es_rd, d) || hazard_hit(i_ms_rd, d) || hazard_hit(i_ws_rd, d);
    exp_valid   = held && !hz;
    exp_allowin = !held || (!hz && i_es_allowin);
    check("ds_to_es_valid", 64'(exp_valid), 64'(o_ds_to_es_valid));
    check("ds_allowin", 64'(exp_allowin), 64'(o_ds_allowin));
    if (exp_valid) begin
      taken = model_branch(d, pend_pc[0], shadow_read(d.rs1), shadow_read(d.rs2), target);
      check("pc", pend_pc[0], o_pc);
      check("rd", 64'(d.rd), 64'(o_rd));
      check("gpr_wen", 64'(d.gpr_wen), 64'(o_gpr_wen));
      check("mem_ren", 64'(d.mem_ren), 64'(o_mem_ren));
      check("mem_wen", 64'(d.mem_wen), 64'(o_mem_wen));
      check("mem_op", 64'(d.funct3), 64'(o_mem_op));
      check("invalid", 64'(!d.legal), 64'(o_invalid));
      check("rs1data", shadow_read(d.rs1), o_rs1data);
      check("rs2data", shadow_read(d.rs2), o_rs2data);
      if (d.legal) begin
        check("imm", d.imm, o_imm);
        check("alu_op", 64'(d.alu_op), 64'(o_alu_op));
        check("alu_src2_sel", 64'(d.src2_reg ? ALU_SRC2_REG : ALU_SRC2_IMM),
              64'(o_alu_src2_sel));
      end
      check("br_sel", 64'(taken), 64'(o_br_sel));
      if (taken) begin
        check("br_target", target, o_br_target);
      end
    end else begin
      check("br_sel", 64'd0, 64'(o_br_sel));
    end
    if (i_ws_wen) begin
      shadow_write(i_ws_waddr, i_ws_wdata);
    end
    if (exp_valid && i_es_allowin) begin
      void'(pend_inst.pop_front());
      void'(pend_pc.pop_front());
      consumed = consumed + 1;
    end
    if (i_fs_to_ds_valid && exp_allowin) begin
      pend_inst.push_back(i_fs_inst);
      pend_pc.push_back(i_fs_pc);
    end
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed = tests_passed + 1;
      $display("test %s passed", cur_test);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s failed with %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic run_test(input string name, input int unsigned br, input int unsigned hz,
                          input int unsigned st, input int unsigned wr);
    int goal;
    cur_test    = name;
    test_errors = 0;
    branch_pct  = br;
    hazard_pct  = hz;
    stall_pct   = st;
    write_pct   = wr;
    goal        = consumed + N_INST;
    while (consumed < goal) begin
      @(posedge i_clk);
      #1;
      drive_inputs();
      #4;
      check_cycle();
    end
    finish_test();
  endtask

  // every register gets a known value before any read is checked
  task automatic preload_gpr();
    for (int i = 1; i < 32; i++) begin
      @(posedge i_clk);
      #1;
      i_ws_wen   = 1'b1;
      i_ws_waddr = reg_addr_t'(i);
      i_ws_wdata = rand_data();
      shadow_write(i_ws_waddr, i_ws_wdata);
    end
    @(posedge i_clk);
    #1;
    i_ws_wen = 1'b0;
  endtask

  initial begin
    seed             = 31;
    i_clk            = 1'b0;
    i_rst            = 1'b1;
    i_es_allowin     = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = NOP_INST;
    i_fs_pc          = '0;
    i_ws_wen         = 1'b0;
    i_ws_waddr       = '0;
    i_ws_wdata       = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    consumed         = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    cur_test         = "reset";
    test_errors      = 0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    #4;
    check("ds_to_es_valid", 64'd0, 64'(o_ds_to_es_valid));
    check("br_sel", 64'd0, 64'(o_br_sel));
    check("ds_allowin", 64'd1, 64'(o_ds_allowin));
    preload_gpr();
    finish_test();

    run_test("decode_mix", 0, 0, 10, 20);
    run_test("gpr_read", 0, 0, 10, 80);
    run_test("hazard_stall", 0, 30, 10, 30);
    run_test("branch_backpressure", 80, 10, 40, 40);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
